// File: hdl/uart_baud_gen.sv
`timescale 1ns/1ps

module uart_baud_gen
  import uart_pkg::*;
#(
  parameter int clk_freq = 10_000_000,
  parameter int baud     = 312_500
) (
  input  logic clk,
  input  logic rst_n,
  output logic tick
);

  // clocks per oversample tick, never below one
  localparam int DIV_RAW = clk_freq / (baud * OVERSAMPLE);
  localparam int DIV     = (DIV_RAW < 1) ? 1 : DIV_RAW;
  localparam int CW      = (DIV > 1) ? $clog2(DIV) : 1;

  logic [CW-1:0] cnt;  // down counter

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt  <= CW'(DIV - 1);  // restart full period
      tick <= 1'b0;
    end else begin
      if (cnt == '0) begin
        cnt  <= CW'(DIV - 1);  // reload
        tick <= 1'b1;          // one-cycle strobe
      end else begin
        cnt  <= cnt - 1'b1;
        tick <= 1'b0;
      end
    end
  end

endmodule

// File: hdl/uart_core.sv
`timescale 1ns/1ps

module uart_core
  import uart_pkg::*;
#(
  parameter int clk_freq = 10_000_000,
  parameter int baud     = 312_500
) (
  input  logic  clk,
  input  logic  rst_n,
  input  byte_t tx_data,
  input  logic  tx_start,
  input  logic  rx_ack,
  input  logic  rxd,
  output logic  txd,
  output byte_t rx_data,
  output logic  rx_avail,
  output logic  rx_error,
  output logic  tx_busy
);

  logic  tick;       // 16x baud strobe
  byte_t rx_byte;    // byte from receiver
  logic  rx_done;    // receiver finished a frame
  logic  frame_err;  // bad stop bit on that frame

  uart_baud_gen #(
    .clk_freq(clk_freq),
    .baud    (baud)
  ) baud0 (
    .clk  (clk),
    .rst_n(rst_n),
    .tick (tick)
  );

  uart_tx tx0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .tick    (tick),
    .tx_data (tx_data),
    .tx_start(tx_start),  // dropped inside while busy
    .tx_busy (tx_busy),
    .txd     (txd)
  );

  uart_rx rx0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .tick     (tick),
    .rxd      (rxd),
    .rx_byte  (rx_byte),
    .rx_done  (rx_done),
    .frame_err(frame_err)
  );

  // receive holding register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_data  <= '0;  // reads as zero until first byte
      rx_avail <= 1'b0;
      rx_error <= 1'b0;
    end else if (rx_done) begin
      rx_data  <= rx_byte;  // newest byte always wins
      rx_avail <= 1'b1;
      // overrun if the last byte was never acknowledged
      rx_error <= frame_err | (rx_avail & !rx_ack);
    end else if (rx_ack) begin
      rx_avail <= 1'b0;
      rx_error <= 1'b0;
    end
  end

endmodule

// File: hdl/uart_pkg.sv
package uart_pkg;

  // widths with a meaning on the bus and serial side
  typedef logic [7:0]  byte_t;      // one serial data byte
  typedef logic [31:0] word_t;      // bus data word
  typedef logic [4:0]  reg_addr_t;  // register address

  // register map
  localparam reg_addr_t ADDR_DATA = 5'h08;  // tx byte on write, rx byte on read
  localparam reg_addr_t ADDR_CTRL = 5'h10;  // commands on write, status on read

  // control word, write side
  localparam int CTRL_TX_START = 0;  // start one frame
  localparam int CTRL_RX_ACK   = 1;  // drop avail and error
  localparam int CTRL_LED      = 2;  // led level

  // status word, read side
  localparam int STAT_TX_BUSY  = 9;
  localparam int STAT_RX_AVAIL = 8;
  localparam int STAT_RX_ERROR = 7;

  // baud ticks per serial bit
  localparam int OVERSAMPLE = 16;

  typedef enum logic [1:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_stop
  } tx_state_t;

  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_t;

endpackage

// File: hdl/uart_regs.sv
`timescale 1ns/1ps

module uart_regs
  import uart_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      cs,
  input  reg_addr_t addr,
  input  logic      rd,
  input  logic      wr,
  input  word_t     d_in,
  output word_t     d_out,
  output byte_t     tx_data,
  output logic      tx_start,
  output logic      rx_ack,
  output logic      ledout,
  input  byte_t     rx_data,
  input  logic      rx_avail,
  input  logic      rx_error,
  input  logic      tx_busy
);

  logic  wr_data;  // write to data register
  logic  wr_ctrl;  // write to control register
  logic  rd_req;   // read request cycle
  word_t rd_word;  // read mux output
  word_t status;   // assembled status word

  assign wr_data = cs && wr && (addr == ADDR_DATA);
  assign wr_ctrl = cs && wr && (addr == ADDR_CTRL);
  assign rd_req  = cs && rd;

  always_comb begin
    status                = '0;
    status[STAT_TX_BUSY]  = tx_busy;
    status[STAT_RX_AVAIL] = rx_avail;
    status[STAT_RX_ERROR] = rx_error;
  end

  always_comb begin
    case (addr)
      ADDR_DATA: rd_word = {24'b0, rx_data};
      ADDR_CTRL: rd_word = status;
      default:   rd_word = '0;  // unmapped reads zero
    endcase
  end

  // transmit byte, held for the core
  always_ff @(posedge clk) begin
    if (wr_data) begin
      tx_data <= d_in[7:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tx_start <= 1'b0;
      rx_ack   <= 1'b0;
      ledout   <= 1'b0;
      d_out    <= '0;
    end else begin
      // commands last one cycle per write
      tx_start <= wr_ctrl && d_in[CTRL_TX_START];
      rx_ack   <= wr_ctrl && d_in[CTRL_RX_ACK];
      if (wr_ctrl) begin
        ledout <= d_in[CTRL_LED];  // level, kept until next ctrl write
      end
      if (rd_req) begin
        d_out <= rd_word;  // holds between reads
      end
    end
  end

endmodule

// File: hdl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx
  import uart_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  tick,
  input  logic  rxd,
  output byte_t rx_byte,
  output logic  rx_done,
  output logic  frame_err
);

  localparam int CW = $clog2(OVERSAMPLE);

  rx_state_t     state_q;
  logic [CW-1:0] tick_cnt;  // ticks since last sample point
  logic [2:0]    bit_idx;   // data bit number
  byte_t         shift_q;   // incoming byte, filled from the msb side
  logic          rxd_meta;  // first sync stage
  logic          rxd_s;     // synchronized line
  logic          rxd_last;  // line value at previous tick
  logic          mid_start; // middle of start bit
  logic          mid_bit;   // middle of data or stop bit

  assign mid_start = tick && (tick_cnt == CW'(OVERSAMPLE / 2 - 1));
  assign mid_bit   = tick && (tick_cnt == CW'(OVERSAMPLE - 1));
  assign rx_byte   = shift_q;  // stable while rx_done is high

  // two-flop synchronizer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rxd_meta <= 1'b1;
      rxd_s    <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_s    <= rxd_meta;
    end
  end

  // shift in lsb first
  always_ff @(posedge clk) begin
    if (state_q == rx_data && mid_bit) begin
      shift_q <= {rxd_s, shift_q[7:1]};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q   <= rx_idle;
      tick_cnt  <= '0;
      bit_idx   <= '0;
      rxd_last  <= 1'b1;
      rx_done   <= 1'b0;
      frame_err <= 1'b0;
    end else begin
      rx_done <= 1'b0;  // default, pulses below
      if (tick) begin
        rxd_last <= rxd_s;  // edge detect only at ticks
      end
      case (state_q)
        rx_idle: begin
          if (tick && rxd_last && !rxd_s) begin
            state_q  <= rx_start;  // falling edge
            tick_cnt <= '0;
          end
        end
        rx_start: begin
          if (mid_start) begin
            tick_cnt <= '0;
            bit_idx  <= '0;
            if (!rxd_s) begin
              state_q <= rx_data;  // real start bit
            end else begin
              state_q <= rx_idle;  // glitch, drop it
            end
          end else if (tick) begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        rx_data: begin
          if (mid_bit) begin
            tick_cnt <= '0;
            bit_idx  <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state_q <= rx_stop;
            end
          end else if (tick) begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        rx_stop: begin
          if (mid_bit) begin
            state_q   <= rx_idle;
            tick_cnt  <= '0;
            rx_done   <= 1'b1;
            frame_err <= !rxd_s;  // stop bit must be high
          end else if (tick) begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        default: state_q <= rx_idle;
      endcase
    end
  end

endmodule

// File: hdl/uart_top.sv
`timescale 1ns/1ps

module uart_top
  import uart_pkg::*;
#(
  parameter int clk_freq = 10_000_000,
  parameter int baud     = 312_500  // divisor 2 at the default clock
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      cs,
  input  reg_addr_t addr,
  input  logic      rd,
  input  logic      wr,
  input  word_t     d_in,
  output word_t     d_out,
  output logic      uart_tx,
  input  logic      uart_rx,
  output logic      ledout
);

  byte_t tx_data;   // held transmit byte
  logic  tx_start;  // one-cycle command
  logic  rx_ack;    // one-cycle command
  byte_t rx_data;   // holding register contents
  logic  rx_avail;
  logic  rx_error;
  logic  tx_busy;

  uart_regs regs0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .cs      (cs),
    .addr    (addr),
    .rd      (rd),
    .wr      (wr),
    .d_in    (d_in),
    .d_out   (d_out),
    .tx_data (tx_data),
    .tx_start(tx_start),
    .rx_ack  (rx_ack),
    .ledout  (ledout),
    .rx_data (rx_data),
    .rx_avail(rx_avail),
    .rx_error(rx_error),
    .tx_busy (tx_busy)
  );

  uart_core #(
    .clk_freq(clk_freq),
    .baud    (baud)
  ) core0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_data (tx_data),
    .tx_start(tx_start),
    .rx_ack  (rx_ack),
    .rxd     (uart_rx),
    .txd     (uart_tx),
    .rx_data (rx_data),
    .rx_avail(rx_avail),
    .rx_error(rx_error),
    .tx_busy (tx_busy)
  );

endmodule

// File: hdl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx
  import uart_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  tick,
  input  byte_t tx_data,
  input  logic  tx_start,
  output logic  tx_busy,
  output logic  txd
);

  localparam int CW = $clog2(OVERSAMPLE);

  // tx_start and tx_data are ports here, so the matching states are named by package
  tx_state_t     state_q;
  logic [CW-1:0] tick_cnt;  // ticks within current bit
  logic [2:0]    bit_idx;   // data bit number
  byte_t         shift_q;   // outgoing byte, lsb on the wire next
  logic          accept;    // command taken in idle
  logic          bit_end;   // last tick of a bit

  assign accept  = (state_q == tx_idle) && !tx_busy && tx_start;
  assign bit_end = tick && (tick_cnt == CW'(OVERSAMPLE - 1));

  // payload path
  always_ff @(posedge clk) begin
    if (accept) begin
      shift_q <= tx_data;                // latch byte on command
    end else if (state_q == uart_pkg::tx_data && bit_end) begin
      shift_q <= {1'b0, shift_q[7:1]};  // next bit into lsb
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q  <= tx_idle;
      tx_busy  <= 1'b0;
      txd      <= 1'b1;  // line idles high
      tick_cnt <= '0;
      bit_idx  <= '0;
    end else begin
      case (state_q)
        tx_idle: begin
          if (accept) begin
            tx_busy <= 1'b1;  // busy one cycle after the pulse
          end else if (tx_busy && tick) begin
            state_q  <= uart_pkg::tx_start;
            txd      <= 1'b0;  // start bit begins on a tick
            tick_cnt <= '0;
          end
        end
        uart_pkg::tx_start: begin
          if (bit_end) begin
            state_q  <= uart_pkg::tx_data;
            txd      <= shift_q[0];  // first data bit
            tick_cnt <= '0;
            bit_idx  <= '0;
          end else if (tick) begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        uart_pkg::tx_data: begin
          if (bit_end) begin
            tick_cnt <= '0;
            if (bit_idx == 3'd7) begin
              state_q <= tx_stop;
              txd     <= 1'b1;  // stop bit
            end else begin
              txd     <= shift_q[1];  // bit that shifts down next
              bit_idx <= bit_idx + 1'b1;
            end
          end else if (tick) begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        tx_stop: begin
          if (bit_end) begin
            state_q <= tx_idle;
            tx_busy <= 1'b0;  // frame done at end of stop bit
          end else if (tick) begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        default: state_q <= tx_idle;
      endcase
    end
  end

endmodule

// File: tests/uart_top_tb.sv
`timescale 1ns/1ps

module uart_top_tb
  import uart_pkg::*;
();

  localparam int BIT_CYCLES  = 32;    // 10 MHz clock at 312.5 kbaud
  localparam int POLL_LIMIT  = 200;   // status reads before giving up
  localparam int START_LIMIT = 2000;  // cycles to wait for a start bit

  localparam word_t TX_BUSY_M  = 32'h1 << STAT_TX_BUSY;
  localparam word_t RX_AVAIL_M = 32'h1 << STAT_RX_AVAIL;
  localparam word_t RX_ERROR_M = 32'h1 << STAT_RX_ERROR;

  logic      clk;
  logic      rst_n;
  logic      cs;
  reg_addr_t addr;
  logic      rd;
  logic      wr;
  word_t     d_in;
  word_t     d_out;
  logic      uart_tx;
  logic      uart_rx;
  logic      ledout;
  integer    seed;  // random byte source

  uart_top #(
    .clk_freq(10_000_000),
    .baud    (312_500)
  ) dut0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .cs     (cs),
    .addr   (addr),
    .rd     (rd),
    .wr     (wr),
    .d_in   (d_in),
    .d_out  (d_out),
    .uart_tx(uart_tx),
    .uart_rx(uart_rx),
    .ledout (ledout)
  );

  always #50 clk = ~clk;  // 100 ns period

  task automatic stop_with_failure();
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check(input string name, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      $display("ERR %0t %s: got %h, expected %h", $time, name, actual, expected);
      stop_with_failure();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out while waiting for %s", what);
    stop_with_failure();
  endtask

  task automatic bus_write(input reg_addr_t a, input word_t d);
    @(posedge clk);
    cs   <= 1'b1;
    wr   <= 1'b1;
    addr <= a;
    d_in <= d;
    @(posedge clk);  // write taken on this edge
    cs <= 1'b0;
    wr <= 1'b0;
  endtask

  task automatic bus_read(input reg_addr_t a, output word_t d);
    @(posedge clk);
    cs   <= 1'b1;
    rd   <= 1'b1;
    addr <= a;
    @(posedge clk);  // d_out loads here
    cs <= 1'b0;
    rd <= 1'b0;
    @(negedge clk);
    d = d_out;  // settled by mid cycle
  endtask

  task automatic read_expect(input reg_addr_t a, input word_t expected, input string name);
    word_t v;
    bus_read(a, v);
    check(name, v, expected);
  endtask

  // one 8N1 frame on uart_rx, then one idle bit
  task automatic send_serial(input byte_t b, input logic stop_bit);
    logic [9:0] frame;
    frame = {stop_bit, b, 1'b0};  // start bit first, lsb next
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      uart_rx <= frame[i];
      repeat (BIT_CYCLES - 1) @(posedge clk);
    end
    @(posedge clk);
    uart_rx <= 1'b1;  // back to idle
    repeat (BIT_CYCLES - 1) @(posedge clk);
  endtask

  task automatic capture_serial(output byte_t b);
    int waited;
    waited = 0;
    b = '0;
    @(negedge clk);
    while (uart_tx !== 1'b0) begin
      if (waited == START_LIMIT) begin
        report_timeout("a start bit on uart_tx");
      end
      waited++;
      @(negedge clk);
    end
    repeat (BIT_CYCLES / 2) @(negedge clk);  // centre of start bit
    check("uart_tx start bit", uart_tx, 1'b0);
    for (int i = 0; i < 8; i++) begin
      repeat (BIT_CYCLES) @(negedge clk);
      b[i] = uart_tx;  // lsb first
    end
    repeat (BIT_CYCLES) @(negedge clk);
    check("uart_tx stop bit", uart_tx, 1'b1);
  endtask

  task automatic poll_status(input word_t mask, input word_t want, output word_t stat);
    int tries;
    tries = 0;
    bus_read(ADDR_CTRL, stat);
    while ((stat & mask) !== want) begin
      if (tries == POLL_LIMIT) begin
        report_timeout("status bits to match");
      end
      tries++;
      bus_read(ADDR_CTRL, stat);
    end
  endtask

  task automatic line_stays_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check("uart_tx idle", uart_tx, 1'b1);
    end
  endtask

  task automatic after_reset();
    @(negedge clk);
    check("uart_tx", uart_tx, 1'b1);
    check("ledout", ledout, 1'b0);
    check("d_out", d_out, 32'h0);
    read_expect(ADDR_CTRL, 32'h0, "status");
    read_expect(ADDR_DATA, 32'h0, "rx data");
    read_expect(5'h04, 32'h0, "unmapped read");
  endtask

  task automatic led_control();
    bus_write(ADDR_CTRL, 32'h1 << CTRL_LED);
    @(negedge clk);
    check("ledout", ledout, 1'b1);
    line_stays_idle(4 * BIT_CYCLES);  // led alone sends nothing
    bus_write(ADDR_CTRL, 32'h0);
    @(negedge clk);
    check("ledout", ledout, 1'b0);
  endtask

  task automatic transmit_frame();
    byte_t sent;
    byte_t got;
    word_t stat;
    word_t mid;
    sent = byte_t'($random(seed));
    bus_write(ADDR_DATA, {24'h0, sent});
    bus_write(ADDR_CTRL, 32'h1 << CTRL_TX_START);
    bus_read(ADDR_CTRL, stat);
    check("tx_busy", stat & TX_BUSY_M, TX_BUSY_M);
    fork
      capture_serial(got);
      begin
        repeat (3 * BIT_CYCLES) @(posedge clk);        // well inside the frame
        bus_write(ADDR_CTRL, 32'h1 << CTRL_TX_START);  // should be dropped
        bus_read(ADDR_CTRL, mid);
        check("tx_busy mid frame", mid & TX_BUSY_M, TX_BUSY_M);
      end
    join
    check("tx frame", {24'h0, got}, {24'h0, sent});
    poll_status(TX_BUSY_M, 32'h0, stat);
    line_stays_idle(2 * BIT_CYCLES);  // no second frame
  endtask

  task automatic receive_frame();
    byte_t b;
    word_t stat;
    b = byte_t'($random(seed));
    send_serial(b, 1'b1);
    poll_status(RX_AVAIL_M, RX_AVAIL_M, stat);
    check("rx_error", stat & RX_ERROR_M, 32'h0);
    read_expect(ADDR_DATA, {24'h0, b}, "rx data");
    bus_write(ADDR_CTRL, 32'h1 << CTRL_RX_ACK);
    read_expect(ADDR_CTRL, 32'h0, "status after ack");
  endtask

  task automatic framing_error();
    byte_t b;
    word_t stat;
    b = byte_t'($random(seed));
    send_serial(b, 1'b0);  // stop bit held low
    poll_status(RX_AVAIL_M, RX_AVAIL_M, stat);
    check("rx_error", stat & RX_ERROR_M, RX_ERROR_M);
    read_expect(ADDR_DATA, {24'h0, b}, "rx data");
    bus_write(ADDR_CTRL, 32'h1 << CTRL_RX_ACK);
    read_expect(ADDR_CTRL, 32'h0, "status after ack");
  endtask

  task automatic receive_overrun();
    byte_t first;
    byte_t second;
    word_t stat;
    first  = byte_t'($random(seed));
    second = byte_t'($random(seed));
    if (second == first) begin
      second = ~first;  // keep the two bytes apart
    end
    send_serial(first, 1'b1);
    send_serial(second, 1'b1);
    poll_status(RX_ERROR_M, RX_ERROR_M, stat);
    check("rx_avail", stat & RX_AVAIL_M, RX_AVAIL_M);
    read_expect(ADDR_DATA, {24'h0, second}, "rx data");
    bus_write(ADDR_CTRL, 32'h1 << CTRL_RX_ACK);
    read_expect(ADDR_CTRL, 32'h0, "status after ack");
  endtask

  initial begin
    seed    = 32'h4280_307d;
    clk     = 1'b0;
    rst_n   = 1'b0;
    cs      = 1'b0;
    addr    = '0;
    rd      = 1'b0;
    wr      = 1'b0;
    d_in    = '0;
    uart_rx = 1'b1;  // line idles high
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    after_reset();
    led_control();
    transmit_frame();
    receive_frame();
    framing_error();
    receive_overrun();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: uart_top.f
hdl/uart_pkg.sv
hdl/uart_baud_gen.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_core.sv
hdl/uart_regs.sv
hdl/uart_top.sv
tests/uart_top_tb.sv
